/* decodeOperands.f */
design/armRegPkg.sv
design/writePortDecoder.sv
design/regSlot.sv
design/readPortMerge.sv
design/immExtender.sv
design/decodeOperands.sv
+incdir+test
test/decodeOperandsTb.sv

/* design/armRegPkg.sv */
`default_nettype none

package armRegPkg;

    // Meaningful widths of the decode operand path
    typedef logic [31:0] dataWord_t;   // Register or operand word
    typedef logic [3:0]  regAddr_t;    // Architectural register index
    typedef logic [23:0] immField_t;   // Immediate field of the instruction
    typedef logic [1:0]  immSelect_t;  // Extension mode

    localparam int NUM_REGS = 16;

    localparam regAddr_t LINK_REG = 4'd14;  // R14 takes the return address
    localparam regAddr_t PC_REG   = 4'd15;  // R15 holds the program counter

    // Immediate extension codes
    localparam immSelect_t IMM_SEL_BYTE       = 2'd0;
    localparam immSelect_t IMM_SEL_UNSIGNED12 = 2'd1;
    localparam immSelect_t IMM_SEL_BRANCH     = 2'd2;
    localparam immSelect_t IMM_SEL_NONE       = 2'd3;

    typedef struct packed {
        logic      enable;
        regAddr_t  dest;
        dataWord_t data;
    } regWrite_t;  // 37 bits, from writeback

    typedef struct packed {
        regAddr_t src1;
        regAddr_t src2;
    } readReq_t;

    typedef struct packed {
        logic      enable;
        dataWord_t value;
    } slotLoad_t;

    // Lane fields are zero unless the read index hits the slot
    typedef struct packed {
        dataWord_t lane1;
        dataWord_t lane2;
        dataWord_t stored;  // Raw register contents
    } slotLanes_t;

endpackage

`default_nettype wire

/* design/decodeOperands.sv */
`timescale 1ns/100ps
`default_nettype none

// Decode-stage operand path
// Sixteen-entry register file with R15 as PC, plus the immediate extender
module decodeOperands (
    input  logic                  clk,
    input  logic                  reset,
    input  armRegPkg::regWrite_t  i_write,
    input  logic                  i_link,
    input  armRegPkg::dataWord_t  i_nextPc,
    input  armRegPkg::readReq_t   i_read,
    input  armRegPkg::immField_t  i_immField,
    input  armRegPkg::immSelect_t i_immSelect,
    output armRegPkg::dataWord_t  o_readData1,
    output armRegPkg::dataWord_t  o_readData2,
    output armRegPkg::dataWord_t  o_pc,
    output armRegPkg::dataWord_t  o_imm32
);

    armRegPkg::slotLoad_t  [armRegPkg::NUM_REGS-1:0] slotLoad;
    armRegPkg::slotLanes_t [armRegPkg::NUM_REGS-1:0] slotLanes;
    armRegPkg::dataWord_t                            pcValue;  // Link source and PC output

    writePortDecoder u_writeDecoder (
        .i_write  (i_write),
        .i_link   (i_link),
        .i_nextPc (i_nextPc),
        .i_pc     (pcValue),
        .o_load   (slotLoad)
    );

    for (genvar slot = 0; slot < armRegPkg::NUM_REGS; slot++) begin : slotGen
        regSlot #(
            .slotIndex (slot)
        ) u_slot (
            .clk     (clk),
            .reset   (reset),
            .i_load  (slotLoad[slot]),
            .i_read  (i_read),
            .o_lanes (slotLanes[slot])
        );
    end

    readPortMerge u_readMerge (
        .i_lanes     (slotLanes),
        .o_readData1 (o_readData1),
        .o_readData2 (o_readData2),
        .o_pc        (pcValue)
    );

    assign o_pc = pcValue;

    // Purely combinational, independent of the register file
    immExtender u_immExtender (
        .i_immField  (i_immField),
        .i_immSelect (i_immSelect),
        .o_imm32     (o_imm32)
    );

endmodule

`default_nettype wire

/* design/immExtender.sv */
`timescale 1ns/100ps
`default_nettype none

// Widens the 24-bit instruction field into a 32-bit operand
module immExtender (
    input  armRegPkg::immField_t  i_immField,
    input  armRegPkg::immSelect_t i_immSelect,
    output armRegPkg::dataWord_t  o_imm32
);

    logic byteSign;    // Sign of the low byte
    logic branchSign;  // Sign of the branch offset

    assign byteSign   = i_immField[7];
    assign branchSign = i_immField[23];

    always_comb begin
        o_imm32 = '0;
        case (i_immSelect)
            armRegPkg::IMM_SEL_BYTE: begin
                o_imm32 = {{24{byteSign}}, i_immField[7:0]};
            end
            armRegPkg::IMM_SEL_UNSIGNED12: begin
                o_imm32 = {20'd0, i_immField[11:0]};
            end
            armRegPkg::IMM_SEL_BRANCH: begin
                // Word offset, shifted up two places
                o_imm32 = {{6{branchSign}}, i_immField, 2'b00};
            end
            armRegPkg::IMM_SEL_NONE: begin
                o_imm32 = '0;
            end
            default: begin
                o_imm32 = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/readPortMerge.sv */
`timescale 1ns/100ps
`default_nettype none

// Collapses the gated slot lanes into the two read results
// Exactly one slot is non-zero on each lane, so an OR is enough
module readPortMerge (
    input  armRegPkg::slotLanes_t [armRegPkg::NUM_REGS-1:0] i_lanes,
    output armRegPkg::dataWord_t                            o_readData1,
    output armRegPkg::dataWord_t                            o_readData2,
    output armRegPkg::dataWord_t                            o_pc
);

    armRegPkg::dataWord_t merge1;
    armRegPkg::dataWord_t merge2;

    always_comb begin
        merge1 = '0;
        merge2 = '0;
        for (int idx = 0; idx < armRegPkg::NUM_REGS; idx++) begin
            merge1 = merge1 | i_lanes[idx].lane1;
            merge2 = merge2 | i_lanes[idx].lane2;
        end
    end

    assign o_readData1 = merge1;
    assign o_readData2 = merge2;

    // Current PC straight from R15, independent of the read indices
    assign o_pc = i_lanes[armRegPkg::PC_REG].stored;

endmodule

`default_nettype wire

/* design/regSlot.sv */
`timescale 1ns/100ps
`default_nettype none

// One architectural register
// Drives its value onto a read lane only when that lane addresses it
module regSlot #(
    parameter int slotIndex = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  armRegPkg::slotLoad_t  i_load,
    input  armRegPkg::readReq_t   i_read,
    output armRegPkg::slotLanes_t o_lanes
);

    armRegPkg::dataWord_t storedValue;
    logic                 hit1;
    logic                 hit2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            storedValue <= '0;
        end else if (i_load.enable) begin
            storedValue <= i_load.value;
        end
    end

    // Address match for each read port
    assign hit1 = (i_read.src1 == armRegPkg::regAddr_t'(slotIndex));
    assign hit2 = (i_read.src2 == armRegPkg::regAddr_t'(slotIndex));

    assign o_lanes.lane1  = hit1 ? storedValue : '0;
    assign o_lanes.lane2  = hit2 ? storedValue : '0;
    assign o_lanes.stored = storedValue;  // Only used for the PC slot

endmodule

`default_nettype wire

/* design/writePortDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

// Per-slot load control for the register file
// R14 and R15 policy sits here so every slot is the same hardware
module writePortDecoder (
    input  armRegPkg::regWrite_t                           i_write,
    input  logic                                           i_link,
    input  armRegPkg::dataWord_t                           i_nextPc,
    input  armRegPkg::dataWord_t                           i_pc,
    output armRegPkg::slotLoad_t [armRegPkg::NUM_REGS-1:0] o_load
);

    logic [armRegPkg::NUM_REGS-1:0] destHit;  // One-hot write target
    logic                           pcWrite;
    armRegPkg::dataWord_t           linkValue;
    armRegPkg::dataWord_t           pcValue;

    // Destination decode, only when the write port is enabled
    always_comb begin
        destHit = '0;
        destHit[i_write.dest] = i_write.enable;
    end

    assign pcWrite = destHit[armRegPkg::PC_REG];

    // Branch-with-link wins over a same-cycle write to R14
    assign linkValue = i_link ? i_pc : i_write.data;

    // PC follows the fetch stage unless it is written explicitly
    assign pcValue = pcWrite ? i_write.data : i_nextPc;

    always_comb begin
        for (int idx = 0; idx < armRegPkg::NUM_REGS; idx++) begin
            o_load[idx].enable = destHit[idx];
            o_load[idx].value  = i_write.data;
        end

        o_load[armRegPkg::LINK_REG].enable = destHit[armRegPkg::LINK_REG] | i_link;
        o_load[armRegPkg::LINK_REG].value  = linkValue;

        o_load[armRegPkg::PC_REG].enable = 1'b1;  // Loads every cycle
        o_load[armRegPkg::PC_REG].value  = pcValue;
    end

endmodule

`default_nettype wire

/* test/operandModel.svh */
`ifndef OPERAND_MODEL_SVH
`define OPERAND_MODEL_SVH

`default_nettype none

// Reference model of the register file and the immediate extender
// The register state lives in the testbench, these functions only compute

typedef armRegPkg::dataWord_t [armRegPkg::NUM_REGS-1:0] modelBank_t;

// 16-bit Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic [15:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
        shifted = shifted ^ 16'hB400;
    end
    return shifted;
endfunction

// Register contents after one rising edge
function automatic modelBank_t nextBank(
    input modelBank_t            bank,
    input armRegPkg::regWrite_t  write,
    input logic                  link,
    input armRegPkg::dataWord_t  pcNext
);
    modelBank_t result;
    logic       hitLink;
    logic       hitPc;

    result  = bank;
    hitLink = write.enable && (write.dest == armRegPkg::LINK_REG);
    hitPc   = write.enable && (write.dest == armRegPkg::PC_REG);

    // Ordinary registers R0 to R13
    for (int idx = 0; idx < armRegPkg::LINK_REG; idx++) begin
        if (write.enable && (write.dest == idx)) begin
            result[idx] = write.data;
        end
    end

    // Link strobe beats the write port
    if (link) begin
        result[armRegPkg::LINK_REG] = bank[armRegPkg::PC_REG];
    end else if (hitLink) begin
        result[armRegPkg::LINK_REG] = write.data;
    end

    // R15 reloads every cycle
    if (hitPc) begin
        result[armRegPkg::PC_REG] = write.data;
    end else begin
        result[armRegPkg::PC_REG] = pcNext;
    end

    return result;
endfunction

// Expected 32-bit operand for one field and select code
function automatic armRegPkg::dataWord_t expectedImm(
    input armRegPkg::immField_t  field,
    input armRegPkg::immSelect_t sel
);
    logic signed [31:0]   wide;
    armRegPkg::dataWord_t result;

    case (sel)
        armRegPkg::IMM_SEL_BYTE: begin
            wide   = $signed(field[7:0]);  // Sign extension from bit 7
            result = wide;
        end
        armRegPkg::IMM_SEL_UNSIGNED12: begin
            result = 32'(field[11:0]);
        end
        armRegPkg::IMM_SEL_BRANCH: begin
            wide   = $signed(field);
            wide   = wide <<< 2;  // Word offset to byte offset
            result = wide;
        end
        default: begin
            result = 32'd0;
        end
    endcase

    return result;
endfunction

// Readable name of a select code for error lines
function automatic string selectName(input armRegPkg::immSelect_t sel);
    string name;
    case (sel)
        armRegPkg::IMM_SEL_BYTE:       name = "byte";
        armRegPkg::IMM_SEL_UNSIGNED12: name = "unsigned12";
        armRegPkg::IMM_SEL_BRANCH:     name = "branch";
        default:                       name = "none";
    endcase
    return name;
endfunction

`default_nettype wire

`endif

/* test/decodeOperandsTb.sv */
`timescale 1ns/100ps
`include "operandModel.svh"
`default_nettype none

module decodeOperandsTb;

    localparam int CLK_PERIOD   = 100;
    localparam int SETTLE       = 10;  // Delay after driving before sampling
    localparam int RESET_CYCLES = 3;
    localparam int WRITE_CYCLES = 200;
    localparam int PC_CYCLES    = 100;
    localparam int LINK_PAIRS   = 60;
    localparam int IMM_FIELDS   = 48;
    localparam int TOTAL_CYCLES = RESET_CYCLES + WRITE_CYCLES + PC_CYCLES
                                + 2 * LINK_PAIRS + 4 * IMM_FIELDS;

    localparam int T_RESET = 0;
    localparam int T_WRITE = 1;
    localparam int T_PC    = 2;
    localparam int T_LINK  = 3;
    localparam int T_IMM   = 4;

    string testNames [0:4] = '{"reset", "write_read", "pc_follow", "link", "imm_extend"};
    int    errorCount [0:4] = '{default: 0};

    logic                  clk = 1'b0;
    logic                  reset;
    armRegPkg::regWrite_t  writeReq;
    logic                  linkStrobe;
    armRegPkg::dataWord_t  nextPc;
    armRegPkg::readReq_t   readReq;
    armRegPkg::immField_t  immField;
    armRegPkg::immSelect_t immSelect;
    armRegPkg::dataWord_t  readData1;
    armRegPkg::dataWord_t  readData2;
    armRegPkg::dataWord_t  pcOut;
    armRegPkg::dataWord_t  imm32;

    modelBank_t  modelBank;
    logic [15:0] lfsrState = 16'd95;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decodeOperands u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_write     (writeReq),
        .i_link      (linkStrobe),
        .i_nextPc    (nextPc),
        .i_read      (readReq),
        .i_immField  (immField),
        .i_immSelect (immSelect),
        .o_readData1 (readData1),
        .o_readData2 (readData2),
        .o_pc        (pcOut),
        .o_imm32     (imm32)
    );

    // Model register file, same edge and reset as the DUT
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            modelBank <= '0;
        end else begin
            modelBank <= nextBank(modelBank, writeReq, linkStrobe, nextPc);
        end
    end

    // One LFSR step per bit, LSB first into the result
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int idx = 0; idx < count; idx++) begin
            bits      = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    task automatic checkWord(
        input int                   testId,
        input string                label,
        input armRegPkg::dataWord_t expected,
        input armRegPkg::dataWord_t actual
    );
        assert (actual === expected) else begin
            $display("** Error %s (%s): expected %h, actual %h at %0t ns",
                     testNames[testId], label, expected, actual, $time);
            errorCount[testId]++;
        end
    endtask

    // Drive one cycle on the falling edge, then compare every output with the model
    task automatic driveCycle(
        input int                    testId,
        input armRegPkg::regWrite_t  write,
        input logic                  link,
        input armRegPkg::dataWord_t  pcNext,
        input armRegPkg::readReq_t   read,
        input armRegPkg::immField_t  field,
        input armRegPkg::immSelect_t sel
    );
        @(negedge clk);
        writeReq   = write;
        linkStrobe = link;
        nextPc     = pcNext;
        readReq    = read;
        immField   = field;
        immSelect  = sel;
        #SETTLE;
        checkWord(testId, "read port 1", modelBank[read.src1], readData1);
        checkWord(testId, "read port 2", modelBank[read.src2], readData2);
        checkWord(testId, "pc", modelBank[armRegPkg::PC_REG], pcOut);
        checkWord(testId, $sformatf("imm %s", selectName(sel)), expectedImm(field, sel), imm32);
    endtask

    initial begin
        armRegPkg::regWrite_t write;
        armRegPkg::readReq_t  read;
        armRegPkg::dataWord_t pcNext;
        armRegPkg::dataWord_t expectPc;
        armRegPkg::dataWord_t pcSeen;
        armRegPkg::immField_t field;
        int                   totalErrors;

        reset      = 1'b1;
        writeReq   = '0;
        linkStrobe = 1'b0;
        nextPc     = '0;
        readReq    = '0;
        immField   = '0;
        immSelect  = armRegPkg::IMM_SEL_BYTE;

        // Everything reads zero during and right after reset
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(negedge clk);
            if (cyc == RESET_CYCLES - 1) begin
                reset = 1'b0;
            end
            readReq = armRegPkg::readReq_t'(randomBits(8));
            #SETTLE;
            checkWord(T_RESET, "read port 1", 32'd0, readData1);
            checkWord(T_RESET, "read port 2", 32'd0, readData2);
            checkWord(T_RESET, "pc", 32'd0, pcOut);
        end

        for (int cyc = 0; cyc < WRITE_CYCLES; cyc++) begin
            write.enable = (randomBits(2) != 0);  // Three writes in four
            write.dest   = armRegPkg::regAddr_t'(randomBits(4) % 14);
            write.data   = randomBits(32);
            pcNext       = randomBits(32);
            read         = armRegPkg::readReq_t'(randomBits(8));
            driveCycle(T_WRITE, write, 1'b0, pcNext, read, '0, armRegPkg::IMM_SEL_NONE);
        end

        expectPc = '0;
        for (int cyc = 0; cyc < PC_CYCLES; cyc++) begin
            write = '0;
            if (randomBits(2) == 0) begin
                write.enable = 1'b1;
                write.dest   = armRegPkg::PC_REG;
                write.data   = randomBits(32);
            end else begin
                // Writes elsewhere must leave the PC following i_nextPc
                write.enable = (randomBits(1) != 0);
                write.dest   = armRegPkg::regAddr_t'(randomBits(4) % 14);
                write.data   = randomBits(32);
            end
            pcNext    = randomBits(32);
            read.src1 = armRegPkg::PC_REG;
            read.src2 = armRegPkg::regAddr_t'(randomBits(4));
            driveCycle(T_PC, write, 1'b0, pcNext, read, '0, armRegPkg::IMM_SEL_NONE);
            if (cyc > 0) begin
                checkWord(T_PC, "pc after previous cycle", expectPc, pcOut);
            end
            expectPc = (write.enable && write.dest == armRegPkg::PC_REG) ? write.data : pcNext;
        end

        for (int pair = 0; pair < LINK_PAIRS; pair++) begin
            write.enable = (randomBits(1) != 0);  // Competing write to R14 half the time
            write.dest   = armRegPkg::LINK_REG;
            write.data   = randomBits(32);
            pcNext       = randomBits(32);
            read.src1    = armRegPkg::PC_REG;
            read.src2    = armRegPkg::regAddr_t'(randomBits(4));
            driveCycle(T_LINK, write, 1'b1, pcNext, read, '0, armRegPkg::IMM_SEL_NONE);
            pcSeen = modelBank[armRegPkg::PC_REG];

            pcNext    = randomBits(32);
            read.src1 = armRegPkg::LINK_REG;
            read.src2 = armRegPkg::PC_REG;
            driveCycle(T_LINK, '0, 1'b0, pcNext, read, '0, armRegPkg::IMM_SEL_NONE);
            checkWord(T_LINK, "r14 after link", pcSeen, readData1);
        end

        // Every field goes through all four select codes
        for (int fieldIdx = 0; fieldIdx < IMM_FIELDS; fieldIdx++) begin
            field = armRegPkg::immField_t'(randomBits(24));
            for (int sel = 0; sel < 4; sel++) begin
                pcNext = randomBits(32);
                read   = armRegPkg::readReq_t'(randomBits(8));
                driveCycle(T_IMM, '0, 1'b0, pcNext, read, field, armRegPkg::immSelect_t'(sel));
            end
        end

        totalErrors = 0;
        foreach (errorCount[idx]) begin
            totalErrors += errorCount[idx];
        end
        $display("Errors: reset %0d, write_read %0d, pc_follow %0d, link %0d, imm_extend %0d",
                 errorCount[T_RESET], errorCount[T_WRITE], errorCount[T_PC],
                 errorCount[T_LINK], errorCount[T_IMM]);
        if (totalErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", TOTAL_CYCLES + 20);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
